//--- src/soc_bus_pkg.sv
// bus address and data types, gpio pin width and machine timer type
package soc_bus_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  // byte address seen on the request channel
  typedef logic [ADDR_W-1:0] addr_t;
  // one register word
  typedef logic [DATA_W-1:0] data_t;

  ////////////////////
  // device widths
  ////////////////////

  // gpio pin count
  localparam int unsigned GPIO_W = 12;
  typedef logic [GPIO_W-1:0] gpio_t;

  // mtime and mtimecmp
  localparam int unsigned MTIME_W = 64;
  typedef logic [MTIME_W-1:0] mtime_t;

endpackage

//--- src/soc_map_pkg.sv
// peripheral address map, slot enum and register offsets of the gpio and clint slots
package soc_map_pkg;

  ////////////////////
  // slot decode
  ////////////////////

  // upper nibble of the byte address picks the device
  localparam soc_bus_pkg::addr_t SLOT_MASK  = 16'hF000;
  localparam soc_bus_pkg::addr_t GPIO_BASE  = 16'h1000;
  localparam soc_bus_pkg::addr_t CLINT_BASE = 16'h2000;

  // in-slot offset carried with a decoded request
  localparam int unsigned OFS_W = 12;
  typedef logic [OFS_W-1:0] ofs_t;

  // decoded target, SLOT_NONE ends in an error response
  typedef enum logic [1:0] {
    SLOT_NONE  = 2'd0,
    SLOT_GPIO  = 2'd1,
    SLOT_CLINT = 2'd2
  } slot_e;

  ////////////////////
  // register offsets
  ////////////////////

  localparam logic [3:0] GPIO_IN_OFS  = 4'h0;
  localparam logic [3:0] GPIO_OUT_OFS = 4'h4;
  localparam logic [3:0] GPIO_DIR_OFS = 4'h8;
  localparam logic [3:0] GPIO_IRQ_OFS = 4'hC;

  localparam logic [4:0] CLINT_MSIP_OFS     = 5'h00;
  localparam logic [4:0] CLINT_MTIME_LO_OFS = 5'h08;
  localparam logic [4:0] CLINT_MTIME_HI_OFS = 5'h0C;
  localparam logic [4:0] CLINT_CMP_LO_OFS   = 5'h10;
  localparam logic [4:0] CLINT_CMP_HI_OFS   = 5'h14;

endpackage

//--- src/periph_bus_if.sv
// decoded request bus between the request stage, the devices and the response stage
`timescale 1ns/1ns

interface periph_bus_if
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
();

  // registered request out of bus_decode
  logic  req_valid;
  logic  req_we;
  slot_e req_slot;
  ofs_t  req_ofs;
  data_t req_wdata;

  // request moves into the response register this cycle
  logic  fire;

  // combinational read data of each device
  data_t gpio_rdata;
  data_t clint_rdata;

  modport decode (output req_valid, req_we, req_slot, req_ofs, req_wdata, input fire);

  modport dev_gpio (input req_valid, req_we, req_slot, req_ofs, req_wdata, fire,
                    output gpio_rdata);

  modport dev_clint (input req_valid, req_we, req_slot, req_ofs, req_wdata, fire,
                     output clint_rdata);

  modport result (input req_valid, req_we, req_slot, req_ofs, req_wdata, gpio_rdata,
                  clint_rdata, output fire);

endinterface

//--- src/bus_decode.sv
// request stage with slot decode and a one-entry request register
`timescale 1ns/1ns

module bus_decode
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_req_valid,
  output logic  o_req_ready,
  input  logic  i_req_we,
  input  addr_t i_req_addr,
  input  data_t i_req_wdata,
  periph_bus_if.decode bus
);

  logic  valid_q;
  logic  we_q;
  slot_e slot_q;
  ofs_t  ofs_q;
  data_t wdata_q;
  slot_e slot_d;
  logic  accept;

  // register is free when empty or when its entry leaves this cycle
  assign o_req_ready = ~valid_q | bus.fire;
  assign accept      = i_req_valid & o_req_ready;

  ////////////////////
  // address decode
  ////////////////////

  always_comb
  begin
    slot_d = SLOT_NONE;
    // compare the upper nibble against each base
    if ((i_req_addr & SLOT_MASK) == GPIO_BASE)
    begin
      slot_d = SLOT_GPIO;
    end
    else if ((i_req_addr & SLOT_MASK) == CLINT_BASE)
    begin
      slot_d = SLOT_CLINT;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      valid_q <= 1'b0;
    end
    else if (accept)
    begin
      valid_q <= 1'b1;
    end
    else if (bus.fire)
    begin
      valid_q <= 1'b0;
    end
  end

  // payload is only looked at while valid_q is set
  always_ff @(posedge i_clk)
  begin
    if (accept)
    begin
      we_q    <= i_req_we;
      slot_q  <= slot_d;
      ofs_q   <= i_req_addr[OFS_W-1:0];
      wdata_q <= i_req_wdata;
    end
  end

  assign bus.req_valid = valid_q;
  assign bus.req_we    = we_q;
  assign bus.req_slot  = slot_q;
  assign bus.req_ofs   = ofs_q;
  assign bus.req_wdata = wdata_q;

endmodule

//--- src/gpio_regs.sv
// gpio output and direction registers, input synchronizer and edge interrupt pending bits
`timescale 1ns/1ns

module gpio_regs
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  periph_bus_if.dev_gpio bus,
  input  gpio_t i_gpio,
  output gpio_t o_gpio,
  output gpio_t o_gpio_dir,
  output logic  o_irq_gpio
);

  gpio_t out_q;
  gpio_t dir_q;
  gpio_t meta_q;
  gpio_t in_q;
  gpio_t prev_q;
  gpio_t pend_q;
  gpio_t rise;
  gpio_t clr;
  logic  hit;
  logic  wr;

  // offsets above 0xC inside the slot are unused
  assign hit = (bus.req_ofs[OFS_W-1:4] == '0);
  assign wr  = bus.fire & bus.req_we & (bus.req_slot == SLOT_GPIO) & hit;

  ////////////////////
  // pin sampling
  ////////////////////

  // two flops toward i_clk, then one more to spot rising edges
  assign rise = in_q & ~prev_q;
  // write one to clear
  assign clr  = (wr && bus.req_ofs[3:0] == GPIO_IRQ_OFS) ? bus.req_wdata[GPIO_W-1:0] : '0;

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      meta_q <= '0;
      in_q   <= '0;
      prev_q <= '0;
      pend_q <= '0;
      out_q  <= '0;
      dir_q  <= '0;
    end
    else
    begin
      meta_q <= i_gpio;
      in_q   <= meta_q;
      prev_q <= in_q;
      // a new edge wins over a clear in the same cycle
      pend_q <= (pend_q & ~clr) | rise;
      if (wr && bus.req_ofs[3:0] == GPIO_OUT_OFS)
      begin
        out_q <= bus.req_wdata[GPIO_W-1:0];
      end
      if (wr && bus.req_ofs[3:0] == GPIO_DIR_OFS)
      begin
        dir_q <= bus.req_wdata[GPIO_W-1:0];
      end
    end
  end

  ////////////////////
  // read mux
  ////////////////////

  always_comb
  begin
    bus.gpio_rdata = '0;
    if (hit)
    begin
      case (bus.req_ofs[3:0])
        GPIO_IN_OFS:  bus.gpio_rdata = {{(DATA_W-GPIO_W){1'b0}}, in_q};
        GPIO_OUT_OFS: bus.gpio_rdata = {{(DATA_W-GPIO_W){1'b0}}, out_q};
        GPIO_DIR_OFS: bus.gpio_rdata = {{(DATA_W-GPIO_W){1'b0}}, dir_q};
        GPIO_IRQ_OFS: bus.gpio_rdata = {{(DATA_W-GPIO_W){1'b0}}, pend_q};
        default:      bus.gpio_rdata = '0;
      endcase
    end
  end

  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;
  assign o_irq_gpio = |pend_q;

endmodule

//--- src/clint_timer.sv
// machine timer, timer compare, software interrupt bit and registered timer interrupt
`timescale 1ns/1ns

module clint_timer
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst_n,
  periph_bus_if.dev_clint bus,
  output logic o_msip,
  output logic o_mtip
);

  mtime_t mtime_q;
  mtime_t cmp_q;
  logic   msip_q;
  logic   mtip_q;
  logic   hit;
  logic   wr;

  // register file ends at 0x14, anything past 0x1F is unused
  assign hit = (bus.req_ofs[OFS_W-1:5] == '0);
  assign wr  = bus.fire & bus.req_we & (bus.req_slot == SLOT_CLINT) & hit;

  ////////////////////
  // timer state
  ////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      mtime_q <= '0;
      // all ones keeps mtip low until software programs a compare
      cmp_q   <= '1;
      msip_q  <= 1'b0;
      mtip_q  <= 1'b0;
    end
    else
    begin
      // free running, one tick per i_clk
      mtime_q <= mtime_q + 1'b1;
      mtip_q  <= (mtime_q >= cmp_q);
      if (wr && bus.req_ofs[4:0] == CLINT_MSIP_OFS)
      begin
        msip_q <= bus.req_wdata[0];
      end
      // compare is written one half at a time
      if (wr && bus.req_ofs[4:0] == CLINT_CMP_LO_OFS)
      begin
        cmp_q[DATA_W-1:0] <= bus.req_wdata;
      end
      if (wr && bus.req_ofs[4:0] == CLINT_CMP_HI_OFS)
      begin
        cmp_q[MTIME_W-1:DATA_W] <= bus.req_wdata;
      end
    end
  end

  ////////////////////
  // read mux
  ////////////////////

  always_comb
  begin
    bus.clint_rdata = '0;
    if (hit)
    begin
      case (bus.req_ofs[4:0])
        CLINT_MSIP_OFS:     bus.clint_rdata = {{(DATA_W-1){1'b0}}, msip_q};
        CLINT_MTIME_LO_OFS: bus.clint_rdata = mtime_q[DATA_W-1:0];
        CLINT_MTIME_HI_OFS: bus.clint_rdata = mtime_q[MTIME_W-1:DATA_W];
        CLINT_CMP_LO_OFS:   bus.clint_rdata = cmp_q[DATA_W-1:0];
        CLINT_CMP_HI_OFS:   bus.clint_rdata = cmp_q[MTIME_W-1:DATA_W];
        default:            bus.clint_rdata = '0;
      endcase
    end
  end

  assign o_msip = msip_q;
  assign o_mtip = mtip_q;

endmodule

//--- src/resp_mux.sv
// response stage with read data select, error flag and a held response register
`timescale 1ns/1ns

module resp_mux
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  periph_bus_if.result bus,
  output logic  o_rsp_valid,
  input  logic  i_rsp_ready,
  output data_t o_rsp_rdata,
  output logic  o_rsp_err
);

  logic  valid_q;
  data_t rdata_q;
  logic  err_q;
  data_t rdata_d;
  logic  err_d;

  // load when empty or when the master takes the current response
  assign bus.fire = bus.req_valid & (~valid_q | i_rsp_ready);

  ////////////////////
  // slot select
  ////////////////////

  always_comb
  begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (bus.req_slot)
      SLOT_GPIO:  rdata_d = bus.gpio_rdata;
      SLOT_CLINT: rdata_d = bus.clint_rdata;
      // unmapped address
      default:    err_d   = 1'b1;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      valid_q <= 1'b0;
    end
    else if (bus.fire)
    begin
      valid_q <= 1'b1;
    end
    else if (i_rsp_ready)
    begin
      // drained with nothing behind it
      valid_q <= 1'b0;
    end
  end

  // data and error stay put while the master stalls
  always_ff @(posedge i_clk)
  begin
    if (bus.fire)
    begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign o_rsp_valid = valid_q;
  assign o_rsp_rdata = rdata_q;
  assign o_rsp_err   = err_q;

endmodule

//--- src/periph_top.sv
// peripheral subsystem top with request decode, gpio, clint and response stage
`timescale 1ns/1ns

module periph_top
  import soc_bus_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  // request channel
  input  logic  i_req_valid,
  output logic  o_req_ready,
  input  logic  i_req_we,
  input  addr_t i_req_addr,
  input  data_t i_req_wdata,
  // response channel
  output logic  o_rsp_valid,
  input  logic  i_rsp_ready,
  output data_t o_rsp_rdata,
  output logic  o_rsp_err,
  // gpio pins and interrupt
  input  gpio_t i_gpio,
  output gpio_t o_gpio,
  output gpio_t o_gpio_dir,
  output logic  o_irq_gpio,
  // clint interrupts
  output logic  o_msip,
  output logic  o_mtip
);

  periph_bus_if bus ();

  ////////////////////
  // decode
  ////////////////////

  bus_decode u_decode (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .i_req_we    (i_req_we),
    .i_req_addr  (i_req_addr),
    .i_req_wdata (i_req_wdata),
    .bus         (bus.decode)
  );

  ////////////////////
  // devices
  ////////////////////

  gpio_regs u_gpio (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .bus        (bus.dev_gpio),
    .i_gpio     (i_gpio),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir),
    .o_irq_gpio (o_irq_gpio)
  );

  clint_timer u_clint (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .bus     (bus.dev_clint),
    .o_msip  (o_msip),
    .o_mtip  (o_mtip)
  );

  // response register toward the master
  resp_mux u_resp (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .bus         (bus.result),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp_rdata (o_rsp_rdata),
    .o_rsp_err   (o_rsp_err)
  );

endmodule

//--- verification/tb_periph_top.sv
// testbench for periph_top with scoreboard, response assertions, timeout and pass/fail report
`timescale 1ns/1ns

module tb_periph_top
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
();

  localparam int unsigned MAX_CYCLES = 3000;
  localparam int unsigned RST_CYCLES = 16;
  // how a response is checked
  localparam logic [1:0] CHK_EXACT = 2'd0;
  localparam logic [1:0] CHK_TIME  = 2'd1;
  localparam logic [1:0] CHK_WRITE = 2'd2;

  logic  i_clk;
  logic  i_rst_n;
  logic  i_req_valid;
  logic  o_req_ready;
  logic  i_req_we;
  addr_t i_req_addr;
  data_t i_req_wdata;
  logic  o_rsp_valid;
  logic  i_rsp_ready;
  data_t o_rsp_rdata;
  logic  o_rsp_err;
  gpio_t i_gpio;
  gpio_t o_gpio;
  gpio_t o_gpio_dir;
  logic  o_irq_gpio;
  logic  o_msip;
  logic  o_mtip;

  // scoreboard with one entry per request in flight
  data_t       exp_data_q[$];
  logic        exp_err_q[$];
  logic [1:0]  exp_kind_q[$];
  int unsigned acc_cyc_q[$];
  int unsigned cycle;
  logic        stall_mode;
  data_t       last_rdata;
  data_t       last_mtime;
  // register model
  gpio_t       m_out;
  gpio_t       m_dir;

  periph_top i_dut (.*);

  always #20 i_clk = ~i_clk;

  // random stalls on the response channel
  always @(posedge i_clk)
  begin
    #2;
    i_rsp_ready = stall_mode ? (($urandom % 3) != 0) : 1'b1;
  end

  ////////////////////
  // checking
  ////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped at cycle %0d", cycle);
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    assert (got == exp)
    else stop_on_error($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  // a stalled response keeps its payload
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp_rdata) && $stable(o_rsp_err)))
  else stop_on_error("response dropped or changed while the master stalled");

  task automatic check_response();
    data_t       exp_d;
    logic        exp_e;
    logic [1:0]  kind;
    int unsigned acc;
    if (exp_data_q.size() == 0 || acc_cyc_q.size() == 0)
    begin
      stop_on_error("response seen with no request outstanding");
    end
    else
    begin
      exp_d = exp_data_q.pop_front();
      exp_e = exp_err_q.pop_front();
      kind  = exp_kind_q.pop_front();
      acc   = acc_cyc_q.pop_front();
      check_value("o_rsp_err", data_t'(o_rsp_err), data_t'(exp_e));
      if (kind == CHK_EXACT)
      begin
        check_value("o_rsp_rdata", o_rsp_rdata, exp_d);
      end
      else if (kind == CHK_TIME)
      begin
        // mtime only has to grow between reads
        assert (o_rsp_rdata > last_mtime)
        else stop_on_error($sformatf("mismatch mtime_lo prev %h got %h", last_mtime, o_rsp_rdata));
        last_mtime = o_rsp_rdata;
      end
      // two cycles from accept to response handshake with no stalls
      if (!stall_mode)
      begin
        check_value("rsp latency", data_t'(cycle - acc), 32'd2);
      end
      last_rdata = o_rsp_rdata;
    end
  endtask

  // handshake monitor and cycle limit
  always @(posedge i_clk)
  begin
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES)
    begin
      stop_on_error($sformatf("timeout after %0d cycles", cycle));
    end
    else if (i_rst_n)
    begin
      if (i_req_valid && o_req_ready)
      begin
        acc_cyc_q.push_back(cycle);
      end
      if (o_rsp_valid && i_rsp_ready)
      begin
        check_response();
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // holds the request until o_req_ready and returns 2 ns after the transfer edge
  task automatic do_req(input logic we, input addr_t addr, input data_t wdata,
                        input data_t exp_d, input logic exp_e, input logic [1:0] kind);
    exp_data_q.push_back(exp_d);
    exp_err_q.push_back(exp_e);
    exp_kind_q.push_back(kind);
    i_req_valid = 1'b1;
    i_req_we    = we;
    i_req_addr  = addr;
    i_req_wdata = wdata;
    @(posedge i_clk);
    while (!o_req_ready)
    begin
      @(posedge i_clk);
    end
    #2;
    i_req_valid = 1'b0;
  endtask

  task automatic write_reg(input addr_t addr, input data_t wdata);
    do_req(1'b1, addr, wdata, '0, 1'b0, CHK_WRITE);
  endtask

  task automatic read_reg(input addr_t addr, input data_t exp_d);
    do_req(1'b0, addr, '0, exp_d, 1'b0, CHK_EXACT);
  endtask

  task automatic wait_idle();
    while (exp_data_q.size() != 0)
    begin
      @(posedge i_clk);
      #2;
    end
  endtask

  // change stall mode only with nothing in flight
  task automatic set_stall(input logic mode);
    wait_idle();
    stall_mode = mode;
    repeat (2) @(posedge i_clk);
    #2;
  endtask

  task automatic check_reset_values();
    check_value("o_req_ready", data_t'(o_req_ready), 32'd1);
    check_value("o_rsp_valid", data_t'(o_rsp_valid), 32'd0);
    check_value("o_msip", data_t'(o_msip), 32'd0);
    check_value("o_mtip", data_t'(o_mtip), 32'd0);
    check_value("o_irq_gpio", data_t'(o_irq_gpio), 32'd0);
    check_value("o_gpio", data_t'(o_gpio), 32'd0);
    check_value("o_gpio_dir", data_t'(o_gpio_dir), 32'd0);
  endtask

  // one random request with the model updated in issue order
  task automatic random_req();
    int unsigned sel;
    data_t       d;
    addr_t       a;
    sel = $urandom % 6;
    d   = $urandom;
    case (sel)
      0:
      begin
        m_out = d[GPIO_W-1:0];
        write_reg(GPIO_BASE + addr_t'(GPIO_OUT_OFS), d);
      end
      1:
      begin
        m_dir = d[GPIO_W-1:0];
        write_reg(GPIO_BASE + addr_t'(GPIO_DIR_OFS), d);
      end
      2: read_reg(GPIO_BASE + addr_t'(GPIO_OUT_OFS), data_t'(m_out));
      3: read_reg(GPIO_BASE + addr_t'(GPIO_DIR_OFS), data_t'(m_dir));
      4:
      begin
        // upper nibble 3 to F has no device
        a = {4'(3 + ($urandom % 13)), 12'(d & 32'hFFC)};
        do_req(1'b0, a, '0, '0, 1'b1, CHK_EXACT);
      end
      default: do_req(1'b0, CLINT_BASE + addr_t'(CLINT_MTIME_LO_OFS), '0, '0, 1'b0, CHK_TIME);
    endcase
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial
  begin
    int unsigned bit_a;
    int unsigned bit_n;
    int unsigned waited;
    data_t       d;
    data_t       mt;
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_req_valid = 1'b0;
    i_req_we    = 1'b0;
    i_req_addr  = '0;
    i_req_wdata = '0;
    i_rsp_ready = 1'b1;
    i_gpio      = '0;
    cycle       = 0;
    stall_mode  = 1'b0;
    last_rdata  = '0;
    last_mtime  = '0;
    m_out       = '0;
    m_dir       = '0;
    void'($urandom(59));
    repeat (RST_CYCLES) @(posedge i_clk);
    #2;
    i_rst_n = 1'b1;
    @(posedge i_clk);
    #2;
    check_reset_values();

    // gpio output and direction with read-back
    repeat (8)
    begin
      d = $urandom;
      m_out = d[GPIO_W-1:0];
      write_reg(GPIO_BASE + addr_t'(GPIO_OUT_OFS), d);
      d = $urandom;
      m_dir = d[GPIO_W-1:0];
      write_reg(GPIO_BASE + addr_t'(GPIO_DIR_OFS), d);
      wait_idle();
      check_value("o_gpio", data_t'(o_gpio), data_t'(m_out));
      check_value("o_gpio_dir", data_t'(o_gpio_dir), data_t'(m_dir));
      read_reg(GPIO_BASE + addr_t'(GPIO_OUT_OFS), data_t'(m_out));
      read_reg(GPIO_BASE + addr_t'(GPIO_DIR_OFS), data_t'(m_dir));
    end

    // unmapped slots error out and unused offsets read zero
    do_req(1'b0, 16'h3000, '0, '0, 1'b1, CHK_EXACT);
    do_req(1'b0, 16'hF004, '0, '0, 1'b1, CHK_EXACT);
    read_reg(GPIO_BASE + 16'h002, '0);
    read_reg(GPIO_BASE + 16'h010, '0);
    read_reg(CLINT_BASE + 16'h004, '0);
    read_reg(CLINT_BASE + 16'h018, '0);
    read_reg(CLINT_BASE + 16'h104, '0);
    // low nibble 4 outside the register block must not hit GPIO_OUT
    write_reg(GPIO_BASE + 16'h014, $urandom);
    wait_idle();
    check_value("o_gpio", data_t'(o_gpio), data_t'(m_out));

    // back-to-back traffic with stalls and then free running
    set_stall(1'b1);
    repeat (120) random_req();
    set_stall(1'b0);
    repeat (40) random_req();
    wait_idle();

    // rising pin edges into the pending register
    bit_a = $urandom % GPIO_W;
    for (int k = 0; k < 3; k++)
    begin
      bit_n  = (bit_a + k * 5) % GPIO_W;
      i_gpio = gpio_t'(1) << bit_n;
      waited = 0;
      do
      begin
        @(posedge i_clk);
        waited++;
      end
      while (!o_irq_gpio && waited < 5);
      assert (o_irq_gpio)
      else stop_on_error("o_irq_gpio did not rise within 5 cycles of a pin edge");
      #2;
      read_reg(GPIO_BASE + addr_t'(GPIO_IRQ_OFS), data_t'(i_gpio));
      read_reg(GPIO_BASE + addr_t'(GPIO_IN_OFS), data_t'(i_gpio));
      write_reg(GPIO_BASE + addr_t'(GPIO_IRQ_OFS), data_t'(i_gpio));
      wait_idle();
      check_value("o_irq_gpio", data_t'(o_irq_gpio), 32'd0);
      read_reg(GPIO_BASE + addr_t'(GPIO_IRQ_OFS), '0);
    end
    i_gpio = '0;

    // software interrupt bit
    write_reg(CLINT_BASE + addr_t'(CLINT_MSIP_OFS), 32'd1);
    wait_idle();
    check_value("o_msip", data_t'(o_msip), 32'd1);
    read_reg(CLINT_BASE + addr_t'(CLINT_MSIP_OFS), 32'd1);
    write_reg(CLINT_BASE + addr_t'(CLINT_MSIP_OFS), 32'd0);
    wait_idle();
    check_value("o_msip", data_t'(o_msip), 32'd0);

    // timer compare 60 ticks ahead of a sampled mtime
    repeat (3) do_req(1'b0, CLINT_BASE + addr_t'(CLINT_MTIME_LO_OFS), '0, '0, 1'b0, CHK_TIME);
    wait_idle();
    mt = last_rdata;
    write_reg(CLINT_BASE + addr_t'(CLINT_CMP_LO_OFS), mt + 32'd60);
    write_reg(CLINT_BASE + addr_t'(CLINT_CMP_HI_OFS), 32'd0);
    wait_idle();
    repeat (40)
    begin
      @(posedge i_clk);
      check_value("o_mtip", data_t'(o_mtip), 32'd0);
    end
    waited = 40;
    while (!o_mtip && waited < 100)
    begin
      @(posedge i_clk);
      waited++;
    end
    assert (o_mtip)
    else stop_on_error("o_mtip did not rise within 100 cycles of the compare write");
    #2;

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- sim.f
src/soc_bus_pkg.sv
src/soc_map_pkg.sv
src/periph_bus_if.sv
src/bus_decode.sv
src/gpio_regs.sv
src/clint_timer.sv
src/resp_mux.sv
src/periph_top.sv
verification/tb_periph_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the periph_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_periph_top -f sim.f -o tb_periph_top
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_periph_top
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
